// ==== Bender.yml ====
package:
  name: refcpu

sources:
  - include_dirs:
      - source
    files:
      - source/refcpu_pkg.sv
      - source/fetch_handoff_if.sv
      - source/fetch_unit.sv
      - source/inst_queue.sv
      - source/exec_unit.sv
      - source/refcpu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_refcpu.sv

// ==== refcpu.f ====
+incdir+source
source/refcpu_pkg.sv
source/fetch_handoff_if.sv
source/fetch_unit.sv
source/inst_queue.sv
source/exec_unit.sv
source/refcpu_top.sv
tb/tb_refcpu.sv

// ==== source/exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "refcpu_settings.svh"

module exec_unit import refcpu_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    fetch_handoff_if.consumer inst_in,
    output dbus_req_t         dreq,
    input  dbus_resp_t        dresp,
    output logic              commit_valid,
    output addr_t             commit_pc,
    output reg_idx_t          commit_rd,
    output word_t             commit_value,
    output logic              halted
);

    exec_state_t state;
    exec_state_t state_n;
    logic        inst_ack;

    // current instruction and load data
    addr_t pc_q;
    word_t inst_q;
    word_t load_q;

    word_t regs [`REFCPU_NREGS];

    // decode fields
    opcode_t    op;
    logic [5:0] funct;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    word_t      simm;
    word_t      rs_val;
    word_t      rt_val;
    word_t      sum_imm;

    // writeback
    reg_idx_t wb_rd;
    word_t    result;
    word_t    wb_value;

    assign op     = opcode_t'(inst_q[31:26]);
    assign funct  = inst_q[5:0];
    assign rs     = inst_q[25:21];
    assign rt     = inst_q[20:16];
    assign rd     = inst_q[15:11];
    assign simm   = {{16{inst_q[15]}}, inst_q[15:0]};
    assign rs_val = regs[rs];
    assign rt_val = regs[rt];

    // ADDIU sum and LW/SW effective address
    assign sum_imm = rs_val + simm;

    // SW leaves the destination at r0
    always_comb begin
        wb_rd  = '0;
        result = '0;
        case (op)
            OP_SPECIAL: begin
                wb_rd  = rd;
                result = rs_val + rt_val;
            end
            OP_ADDIU: begin
                wb_rd  = rt;
                result = sum_imm;
            end
            OP_LW: begin
                wb_rd  = rt;
                result = load_q;
            end
            default: ;
        endcase
    end

    // r0 writes report zero
    assign wb_value = (wb_rd == '0) ? '0 : result;

    // next state decoded once the handoff has completed
    always_comb begin
        state_n = state;
        case (state)
            S_DECODE: begin
                if (inst_ack && !inst_in.req) begin
                    case (op)
                        OP_SPECIAL: state_n = (funct == FUNCT_ADDU) ? S_COMMIT : S_UNKNOWN;
                        OP_ADDIU:   state_n = S_COMMIT;
                        OP_LW,
                        OP_SW:      state_n = S_MEM;
                        default:    state_n = S_UNKNOWN;
                    endcase
                end
            end
            S_MEM: begin
                if (dresp.data_ok)
                    state_n = S_COMMIT;
            end
            S_COMMIT: state_n = S_DECODE;
            default:  state_n = S_UNKNOWN;
        endcase

        // invalid state ends in halt
        if (state_n > LAST_EXEC_STATE)
            state_n = S_UNKNOWN;
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state    <= S_DECODE;
            inst_ack <= 1'b0;
        end else begin
            state <= state_n;
            // four-phase consumer that only listens in DECODE
            if (state == S_DECODE) begin
                if (!inst_ack && inst_in.req)
                    inst_ack <= 1'b1;
                else if (inst_ack && !inst_in.req)
                    inst_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DECODE && !inst_ack && inst_in.req) begin
            pc_q   <= inst_in.pc;
            inst_q <= inst_in.inst;
        end
        if (state == S_MEM && dresp.data_ok)
            load_q <= dresp.rdata;
    end

    // r0 cleared in reset and rewritten with zero
    always_ff @(posedge clk) begin
        if (resetn)
            regs[0] <= '0;
        else if (state == S_COMMIT)
            regs[wb_rd] <= wb_value;
    end

    assign inst_in.ack = inst_ack;

    // data bus held through MEM until data_ok
    assign dreq.valid = (state == S_MEM);
    assign dreq.wen   = (op == OP_SW);
    assign dreq.addr  = sum_imm;
    assign dreq.wdata = rt_val;

    // retirement checkpoint
    assign commit_valid = (state == S_COMMIT);
    assign commit_pc    = pc_q;
    assign commit_rd    = wb_rd;
    assign commit_value = wb_value;
    assign halted       = (state == S_UNKNOWN);

    // r0 survives every writeback
    a_r0_zero: assert property (@(posedge clk) disable iff (resetn)
        regs[0] == '0);

    // only a load or store reaches the data bus
    a_dreq_in_mem: assert property (@(posedge clk) disable iff (resetn)
        dreq.valid |-> op == OP_LW || op == OP_SW);

endmodule

`default_nettype wire

// ==== source/fetch_handoff_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// one fetched instruction with its pc, four-phase req/ack
interface fetch_handoff_if import refcpu_pkg::*; ();

    // producer holds pc and inst stable while req is high
    logic  req;
    logic  ack;
    addr_t pc;
    word_t inst;

    // side that owns the instruction
    modport producer (
        output req,
        output pc,
        output inst,
        input  ack
    );

    // side that takes it
    // ack only after pc and inst are captured
    modport consumer (
        input  req,
        input  pc,
        input  inst,
        output ack
    );

endinterface

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "refcpu_settings.svh"

module fetch_unit import refcpu_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    output ibus_req_t         ireq,
    input  ibus_resp_t        iresp,
    fetch_handoff_if.producer handoff
);

    // request -> wait data -> handoff -> wait ack low
    typedef enum logic [1:0] {
        F_REQUEST      = 2'd0,
        F_WAIT_DATA    = 2'd1,
        F_HANDOFF      = 2'd2,
        F_WAIT_ACK_LOW = 2'd3
    } fetch_state_t;

    fetch_state_t state;
    addr_t        fetch_pc;
    word_t        inst_q;

    // bus request only while waiting for the word
    assign ireq.valid = (state == F_WAIT_DATA);
    assign ireq.addr  = fetch_pc;

    // pc still points at the fetched word during the handoff
    assign handoff.req  = (state == F_HANDOFF);
    assign handoff.pc   = fetch_pc;
    assign handoff.inst = inst_q;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state    <= F_REQUEST;
            fetch_pc <= `REFCPU_RESET_PC;
        end else begin
            case (state)
                // one idle cycle so valid drops between requests
                F_REQUEST: state <= F_WAIT_DATA;
                F_WAIT_DATA: begin
                    if (iresp.data_ok)
                        state <= F_HANDOFF;
                end
                // full queue stalls us here by holding back ack
                F_HANDOFF: begin
                    if (handoff.ack) begin
                        state    <= F_WAIT_ACK_LOW;
                        fetch_pc <= fetch_pc + 32'd4;
                    end
                end
                F_WAIT_ACK_LOW: begin
                    if (!handoff.ack)
                        state <= F_REQUEST;
                end
                default: state <= F_REQUEST;
            endcase
        end
    end

    // word latched as the bus answers
    always_ff @(posedge clk) begin
        if (state == F_WAIT_DATA && iresp.data_ok)
            inst_q <= iresp.data;
    end

    // address held until the bus answers
    a_ireq_addr_stable: assert property (@(posedge clk) disable iff (resetn)
        ireq.valid && !iresp.data_ok |=> ireq.valid && $stable(ireq.addr));

    // four-phase rule toward the queue
    a_req_held_until_ack: assert property (@(posedge clk) disable iff (resetn)
        handoff.req && !handoff.ack |=> handoff.req);

endmodule

`default_nettype wire

// ==== source/inst_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "refcpu_settings.svh"

module inst_queue import refcpu_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    fetch_handoff_if.consumer in_port,
    fetch_handoff_if.producer out_port
);

    localparam int DEPTH = `REFCPU_IQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // entry storage
    addr_t pc_mem   [DEPTH];
    word_t inst_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // one handshake engine per side
    logic in_ack;
    logic out_req;

    logic full;
    logic empty;
    logic push;
    logic pop;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // new transfer is req high while our ack is still low
    assign push = in_port.req && !in_ack && !full;
    assign pop  = out_req && out_port.ack;

    assign in_port.ack = in_ack;

    // head entry stays stable while req is up
    assign out_port.req  = out_req;
    assign out_port.pc   = pc_mem[rd_ptr];
    assign out_port.inst = inst_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]   <= in_port.pc;
            inst_mem[wr_ptr] <= in_port.inst;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            in_ack  <= 1'b0;
            out_req <= 1'b0;
        end else begin
            // ack goes up the cycle after capture
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
                in_ack <= 1'b1;
            end else if (in_ack && !in_port.req) begin
                in_ack <= 1'b0;
            end

            // next entry offered only once ack is low
            if (pop) begin
                rd_ptr  <= rd_ptr + 1'b1;
                out_req <= 1'b0;
            end else if (!out_req && !out_port.ack && !empty) begin
                out_req <= 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // occupancy never passes the depth so no push lands on a full queue
    a_no_push_full: assert property (@(posedge clk) disable iff (resetn)
        count <= CNT_W'(DEPTH));

    // never offer an entry we do not hold
    a_no_pop_empty: assert property (@(posedge clk) disable iff (resetn)
        out_port.req |-> !empty);

endmodule

`default_nettype wire

// ==== source/refcpu_pkg.sv ====
`default_nettype none

`include "refcpu_settings.svh"

package refcpu_pkg;

    // basic data and address words
    typedef logic [`REFCPU_XLEN-1:0] word_t;
    typedef logic [`REFCPU_XLEN-1:0] addr_t;

    // register index, 5 bits for 32 registers
    typedef logic [$clog2(`REFCPU_NREGS)-1:0] reg_idx_t;

    // instruction bus request
    // valid held with a fixed addr until data_ok
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } ibus_req_t;

    // instruction bus response, data_ok lasts one cycle
    typedef struct packed {
        logic  data_ok;
        word_t data;
    } ibus_resp_t;

    // data bus request
    typedef struct packed {
        logic  valid;
        logic  wen;
        addr_t addr;
        word_t wdata;
    } dbus_req_t;

    // data bus response
    // rdata only meaningful for loads
    typedef struct packed {
        logic  data_ok;
        word_t rdata;
    } dbus_resp_t;

    // execute unit states
    typedef enum logic [1:0] {
        S_DECODE  = 2'd0,
        S_MEM     = 2'd1,
        S_COMMIT  = 2'd2,
        S_UNKNOWN = 2'd3
    } exec_state_t;

    // anything above this counts as an invalid state
    localparam exec_state_t LAST_EXEC_STATE = S_UNKNOWN;

    // primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // function field of ADDU under OP_SPECIAL
    localparam logic [5:0] FUNCT_ADDU = 6'h21;

endpackage

`default_nettype wire

// ==== source/refcpu_settings.svh ====
`ifndef REFCPU_SETTINGS_SVH
`define REFCPU_SETTINGS_SVH

// data and address width in bits
`define REFCPU_XLEN 32

// architectural registers, r0 included
`define REFCPU_NREGS 32

// instruction queue entries
// keep to a power of two, pointers wrap naturally
`define REFCPU_IQ_DEPTH 4

// first fetch address after reset
`define REFCPU_RESET_PC 32'hBFC0_0000

`endif

// ==== source/refcpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "refcpu_settings.svh"

module refcpu_top import refcpu_pkg::*; (
    input  logic                    clk,
    input  logic                    resetn,
    // instruction bus
    output logic                    ireq_valid,
    output logic [`REFCPU_XLEN-1:0] ireq_addr,
    input  logic                    iresp_data_ok,
    input  logic [`REFCPU_XLEN-1:0] iresp_data,
    // data bus
    output logic                    dreq_valid,
    output logic                    dreq_wen,
    output logic [`REFCPU_XLEN-1:0] dreq_addr,
    output logic [`REFCPU_XLEN-1:0] dreq_wdata,
    input  logic                    dresp_data_ok,
    input  logic [`REFCPU_XLEN-1:0] dresp_rdata,
    // commit checkpoint
    output logic                    commit_valid,
    output logic [`REFCPU_XLEN-1:0] commit_pc,
    output reg_idx_t                commit_rd,
    output logic [`REFCPU_XLEN-1:0] commit_value,
    output logic                    halted
);

    ibus_req_t  ireq;
    ibus_resp_t iresp;
    dbus_req_t  dreq;
    dbus_resp_t dresp;

    fetch_handoff_if fetch_to_queue ();
    fetch_handoff_if queue_to_exec ();

    // flat ports to and from the bus structs
    assign ireq_valid = ireq.valid;
    assign ireq_addr  = ireq.addr;
    assign iresp      = '{data_ok: iresp_data_ok, data: iresp_data};

    assign dreq_valid = dreq.valid;
    assign dreq_wen   = dreq.wen;
    assign dreq_addr  = dreq.addr;
    assign dreq_wdata = dreq.wdata;
    assign dresp      = '{data_ok: dresp_data_ok, rdata: dresp_rdata};

    fetch_unit u_fetch (
        .clk     (clk),
        .resetn  (resetn),
        .ireq    (ireq),
        .iresp   (iresp),
        .handoff (fetch_to_queue.producer)
    );

    inst_queue u_queue (
        .clk      (clk),
        .resetn   (resetn),
        .in_port  (fetch_to_queue.consumer),
        .out_port (queue_to_exec.producer)
    );

    exec_unit u_exec (
        .clk          (clk),
        .resetn       (resetn),
        .inst_in      (queue_to_exec.consumer),
        .dreq         (dreq),
        .dresp        (dresp),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .halted       (halted)
    );

endmodule

`default_nettype wire

// ==== tb/refcpu_stimulus.txt ====
# I addr word | D addr word | E pc rd value | M addr word
# every field is hex, rd 0 means no register result
I bfc00000 24010100
I bfc00004 2402ffff
I bfc00008 8c230000
I bfc0000c 00622021
I bfc00010 8c250004
I bfc00014 00a53021
I bfc00018 24201234
I bfc0001c 00043821
I bfc00020 ac24000c
I bfc00024 2428fff8
I bfc00028 ad020010
I bfc0002c 8c29000c
I bfc00030 8c0a0108
I bfc00034 254b7fff
I bfc00038 01696021
I bfc0003c ac2c0010
I bfc00040 fc000000
D 00000100 11111111
D 00000104 80000000
D 00000108 deadbeef
E bfc00000 01 00000100
E bfc00004 02 ffffffff
E bfc00008 03 11111111
E bfc0000c 04 11111110
E bfc00010 05 80000000
E bfc00014 06 00000000
E bfc00018 00 00000000
E bfc0001c 07 11111110
E bfc00020 00 00000000
E bfc00024 08 000000f8
E bfc00028 00 00000000
E bfc0002c 09 11111110
E bfc00030 0a ffffffff
E bfc00034 0b 00007ffe
E bfc00038 0c 1111910e
E bfc0003c 00 00000000
M 00000100 11111111
M 00000104 80000000
M 00000108 ffffffff
M 0000010c 11111110
M 00000110 1111910e

// ==== tb/tb_refcpu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "refcpu_settings.svh"

module tb_refcpu import refcpu_pkg::*; ();

    localparam addr_t RESET_PC     = `REFCPU_RESET_PC;
    localparam addr_t DATA_BASE    = 32'h0000_0100;
    localparam int    IMEM_WORDS   = 64;
    localparam int    DMEM_WORDS   = 64;
    localparam int    MAX_DELAY    = 5;
    localparam int    DRAIN_CYCLES = 20;

    logic     clk;
    logic     resetn;
    logic     ireq_valid;
    addr_t    ireq_addr;
    logic     iresp_data_ok;
    word_t    iresp_data;
    logic     dreq_valid;
    logic     dreq_wen;
    addr_t    dreq_addr;
    word_t    dreq_wdata;
    logic     dresp_data_ok;
    word_t    dresp_rdata;
    logic     commit_valid;
    addr_t    commit_pc;
    reg_idx_t commit_rd;
    word_t    commit_value;
    logic     halted;

    // memory images behind both buses
    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];

    // expected commits in program order and expected final memory
    addr_t    exp_pc    [$];
    reg_idx_t exp_rd    [$];
    word_t    exp_value [$];
    addr_t    mem_addr  [$];
    word_t    mem_value [$];

    integer seed = 41580;
    int     value_errors = 0;
    int     other_errors = 0;
    int     commits = 0;
    int     n_expected = 0;
    logic   loaded = 1'b0;

    refcpu_top DUT (
        .clk           (clk),
        .resetn        (resetn),
        .ireq_valid    (ireq_valid),
        .ireq_addr     (ireq_addr),
        .iresp_data_ok (iresp_data_ok),
        .iresp_data    (iresp_data),
        .dreq_valid    (dreq_valid),
        .dreq_wen      (dreq_wen),
        .dreq_addr     (dreq_addr),
        .dreq_wdata    (dreq_wdata),
        .dresp_data_ok (dresp_data_ok),
        .dresp_rdata   (dresp_rdata),
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .commit_rd     (commit_rd),
        .commit_value  (commit_value),
        .halted        (halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // word slot of a fetch address or -1 outside the program area
    function automatic int imem_index(addr_t a);
        addr_t off;
        off = a - RESET_PC;
        if (a >= RESET_PC && a[1:0] == 2'b00 && off[31:2] < IMEM_WORDS)
            return int'(off[31:2]);
        return -1;
    endfunction

    function automatic int dmem_index(addr_t a);
        addr_t off;
        off = a - DATA_BASE;
        if (a >= DATA_BASE && a[1:0] == 2'b00 && off[31:2] < DMEM_WORDS)
            return int'(off[31:2]);
        return -1;
    endfunction

    task automatic load_stimulus();
        int       fd;
        int       n;
        string    line;
        addr_t    a;
        word_t    w;
        reg_idx_t r;
        // fill patterns first so file lines overwrite them
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = ~(RESET_PC + addr_t'(4 * i));
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] = (DATA_BASE + addr_t'(4 * i)) ^ 32'hA5A5_A5A5;
        fd = $fopen("tb/refcpu_stimulus.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the stimulus file tb/refcpu_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1) begin
                    case (line[0])
                        "I": begin
                            n = $sscanf(line, "I %h %h", a, w);
                            if (imem_index(a) >= 0)
                                imem[imem_index(a)] = w;
                        end
                        "D": begin
                            n = $sscanf(line, "D %h %h", a, w);
                            if (dmem_index(a) >= 0)
                                dmem[dmem_index(a)] = w;
                        end
                        "E": begin
                            n = $sscanf(line, "E %h %h %h", a, r, w);
                            exp_pc.push_back(a);
                            exp_rd.push_back(r);
                            exp_value.push_back(w);
                            n_expected++;
                        end
                        "M": begin
                            n = $sscanf(line, "M %h %h", a, w);
                            mem_addr.push_back(a);
                            mem_value.push_back(w);
                        end
                        "#": ;
                        default: begin
                            other_errors++;
                            $display("stimulus file has a line with an unknown tag: %s", line);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    task automatic check_commit(input addr_t pc, input reg_idx_t rd, input word_t value);
        if (commit_pc !== pc || commit_rd !== rd || commit_value !== value) begin
            value_errors++;
            $display("ERR %0t: commit pc %h rd %0d value %h, expected pc %h rd %0d value %h",
                     $time, commit_pc, commit_rd, commit_value, pc, rd, value);
        end
    endtask

    task automatic check_mem(input addr_t a, input word_t value);
        if (dmem_index(a) < 0) begin
            other_errors++;
            $display("expected memory word at %h lies outside the data memory model", a);
        end else if (dmem[dmem_index(a)] !== value) begin
            value_errors++;
            $display("ERR %0t: memory at %h holds %h, expected %h",
                     $time, a, dmem[dmem_index(a)], value);
        end
    endtask

    task automatic check_halt(input logic expected);
        if (halted !== expected) begin
            value_errors++;
            $display("ERR %0t: halted is %b, expected %b", $time, halted, expected);
        end
    endtask

    // instruction memory answers after 0 to MAX_DELAY cycles
    initial begin : ibus_model
        int delay;
        iresp_data_ok = 1'b0;
        iresp_data    = '0;
        forever begin
            @(negedge clk);
            iresp_data_ok = 1'b0;
            // reset is asserted while resetn is high
            if (!resetn && ireq_valid) begin
                delay = $unsigned($random(seed)) % (MAX_DELAY + 1);
                repeat (delay) @(negedge clk);
                if (imem_index(ireq_addr) >= 0)
                    iresp_data = imem[imem_index(ireq_addr)];
                else
                    iresp_data = ~ireq_addr;
                iresp_data_ok = 1'b1;
            end
        end
    end

    // data memory with the same latency range
    initial begin : dbus_model
        int delay;
        dresp_data_ok = 1'b0;
        dresp_rdata   = '0;
        forever begin
            @(negedge clk);
            dresp_data_ok = 1'b0;
            if (!resetn && dreq_valid) begin
                delay = $unsigned($random(seed)) % (MAX_DELAY + 1);
                repeat (delay) @(negedge clk);
                if (dmem_index(dreq_addr) < 0) begin
                    other_errors++;
                    $display("data access at %h falls outside the data memory model", dreq_addr);
                    dresp_rdata = '0;
                end else if (dreq_wen) begin
                    dmem[dmem_index(dreq_addr)] = dreq_wdata;
                end else begin
                    dresp_rdata = dmem[dmem_index(dreq_addr)];
                end
                dresp_data_ok = 1'b1;
            end
        end
    end

    // every retirement matched against the next E line
    initial begin : commit_monitor
        forever begin
            @(negedge clk);
            if (!resetn && commit_valid) begin
                if (exp_pc.size() == 0) begin
                    other_errors++;
                    $display("commit at pc %h came after the last expected one", commit_pc);
                end else begin
                    check_commit(exp_pc.pop_front(), exp_rd.pop_front(),
                                 exp_value.pop_front());
                end
                commits++;
            end
        end
    end

    // limit grows with the number of expected commits
    initial begin : watchdog
        wait (loaded);
        repeat (n_expected * 40 + 200) @(posedge clk);
        $display("timeout: the CPU did not halt within %0d cycles", n_expected * 40 + 200);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        resetn = 1'b1;
        load_stimulus();
        repeat (4) @(posedge clk);
        @(negedge clk);
        resetn = 1'b0;
        // halted stays low out of reset
        check_halt(1'b0);

        // run to the undefined opcode and make sure nothing else retires
        while (!halted)
            @(negedge clk);
        repeat (DRAIN_CYCLES) @(negedge clk);
        check_halt(1'b1);
        if (commits != n_expected) begin
            other_errors++;
            $display("saw %0d commits but the stimulus file expects %0d", commits, n_expected);
        end
        foreach (mem_addr[i])
            check_mem(mem_addr[i], mem_value[i]);

        $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
